//--- design/gpioBank.sv
`timescale 1ns/10ps
`include "mcsSys_defs.svh"

module gpioBank (
  input  logic               Clk,            // system clock
  input  logic               reset,          // sync, high
  input  logic               ioAddrStrobe,   // io bus address strobe
  input  logic               ioReadStrobe,   // io bus read strobe
  input  logic               ioWriteStrobe,  // io bus write strobe
  input  mcsSysPkg::busAddrT ioAddress,      // io bus address
  input  mcsSysPkg::busDataT ioWriteData,    // io bus write data
  output mcsSysPkg::busDataT ioReadData,     // valid with ioReady
  output logic               ioReady,        // one cycle after the strobe
  input  mcsSysPkg::ledT     dipSw,          // board switches, async
  output mcsSysPkg::ledT     led             // board leds, high = on
);

  mcsSysPkg::ledT  dipMeta;  // switch sync stage 1
  mcsSysPkg::ledT  dipSync;  // switch sync stage 2
  mcsSysPkg::byteT gpoReg;   // output register
  logic            writeHit;
  logic            readHit;

  assign writeHit = ioAddrStrobe && ioWriteStrobe;
  assign readHit  = ioAddrStrobe && ioReadStrobe;
  assign led      = gpoReg[3:0];

  always_ff @(posedge Clk) begin
    if (reset) begin
      gpoReg  <= '0;
      ioReady <= 1'b0;
    end else begin
      ioReady <= writeHit || readHit;  // registered ack
      if (writeHit && ioAddress == `ADDR_GPO) gpoReg <= ioWriteData[7:0];
    end
  end

  // switch sync and read mux
  always_ff @(posedge Clk) begin
    dipMeta <= dipSw;
    dipSync <= dipMeta;
    if (readHit) begin
      case (ioAddress)
        `ADDR_GPO: ioReadData <= {24'h00_0000, gpoReg};
        `ADDR_GPI: ioReadData <= {28'h000_0000, dipSync};
        default:   ioReadData <= '0;  // unmapped reads as zero
      endcase
    end
  end

endmodule

//--- design/hostCommandEngine.sv
`timescale 1ns/10ps
`include "mcsSys_defs.svh"

module hostCommandEngine (
  input  logic               Clk,            // system clock
  input  logic               reset,          // sync, high
  input  mcsSysPkg::byteT    rxByte,         // byte from the host
  input  logic               rxValid,        // byte strobe
  output logic               ioAddrStrobe,   // io bus address strobe
  output logic               ioReadStrobe,   // io bus read strobe
  output logic               ioWriteStrobe,  // io bus write strobe
  output mcsSysPkg::busAddrT ioAddress,      // io bus address
  output mcsSysPkg::busDataT ioWriteData,    // io bus write data
  input  mcsSysPkg::busDataT ioReadData,     // io bus read data
  input  logic               ioReady,        // slave done, one cycle
  output mcsSysPkg::byteT    txByte,         // reply byte
  output logic               txStart,        // reply load strobe
  input  logic               txBusy          // transmitter occupied
);

  mcsSysPkg::cmdStateT state;
  logic                isRead;     // current command is a read
  mcsSysPkg::byteT     addrByte;   // host address byte
  mcsSysPkg::byteT     dataByte;   // host write data byte
  mcsSysPkg::byteT     replyByte;  // latched read result

  // ------------------------------------------------
  // command FSM
  // ------------------------------------------------
  always_ff @(posedge Clk) begin
    if (reset) begin
      state  <= mcsSysPkg::idle;
      isRead <= 1'b0;
    end else begin
      case (state)
        mcsSysPkg::idle: begin
          if (rxValid) begin
            if (rxByte == `CMD_WRITE) begin
              isRead <= 1'b0;
              state  <= mcsSysPkg::getAddr;
            end else if (rxByte == `CMD_READ) begin
              isRead <= 1'b1;
              state  <= mcsSysPkg::getAddr;
            end  // unknown codes ignored
          end
        end
        mcsSysPkg::getAddr: begin
          if (rxValid) state <= isRead ? mcsSysPkg::busRead : mcsSysPkg::getData;
        end
        mcsSysPkg::getData: begin
          if (rxValid) state <= mcsSysPkg::busWrite;
        end
        mcsSysPkg::busWrite,
        mcsSysPkg::busRead: begin
          state <= mcsSysPkg::waitReady;  // strobes last one cycle
        end
        mcsSysPkg::waitReady: begin
          if (ioReady) state <= isRead ? mcsSysPkg::sendReply : mcsSysPkg::idle;
        end
        mcsSysPkg::sendReply: begin
          if (!txBusy) state <= mcsSysPkg::idle;  // txStart fires this cycle
        end
        default: state <= mcsSysPkg::idle;
      endcase
    end
  end

  // ------------------------------------------------
  // payload capture
  // ------------------------------------------------
  always_ff @(posedge Clk) begin
    if (rxValid && state == mcsSysPkg::getAddr) begin
      addrByte <= rxByte;
    end
    if (rxValid && state == mcsSysPkg::getData) begin
      dataByte <= rxByte;
    end
    if (ioReady && state == mcsSysPkg::waitReady) begin
      replyByte <= ioReadData[7:0];  // only the low byte goes back
    end
  end

  // bus strobes straight from state
  assign ioWriteStrobe = (state == mcsSysPkg::busWrite);
  assign ioReadStrobe  = (state == mcsSysPkg::busRead);
  assign ioAddrStrobe  = ioWriteStrobe || ioReadStrobe;
  assign ioAddress     = {24'h00_0000, addrByte};  // zero-extended
  assign ioWriteData   = {24'h00_0000, dataByte};

  // reply handoff
  assign txByte  = replyByte;
  assign txStart = (state == mcsSysPkg::sendReply) && !txBusy;

endmodule

//--- design/mcsSys.sv
`timescale 1ns/10ps

module mcsSys (
  input  logic           Clk,     // board clock
  input  logic           reset,   // sync, high
  input  logic           uartRx,  // host serial in
  output logic           uartTx,  // host serial out
  output mcsSysPkg::ledT led,     // board leds
  input  mcsSysPkg::ledT dipSw    // board switches
);

  // ------------------------------------------------
  // internal nets
  // ------------------------------------------------
  mcsSysPkg::byteT    rxByte;
  logic               rxValid;
  mcsSysPkg::byteT    txByte;
  logic               txStart;
  logic               txBusy;
  logic               ioAddrStrobe;
  logic               ioReadStrobe;
  logic               ioWriteStrobe;
  mcsSysPkg::busAddrT ioAddress;
  mcsSysPkg::busDataT ioWriteData;
  mcsSysPkg::busDataT ioReadData;
  logic               ioReady;

  uartReceiver i_uartReceiver (
    .Clk(Clk), .reset(reset), .uartRx(uartRx), .rxByte(rxByte), .rxValid(rxValid)
  );

  // io bus master driven by host commands
  hostCommandEngine i_hostCommandEngine (
    .Clk(Clk), .reset(reset), .rxByte(rxByte), .rxValid(rxValid),
    .ioAddrStrobe(ioAddrStrobe), .ioReadStrobe(ioReadStrobe),
    .ioWriteStrobe(ioWriteStrobe), .ioAddress(ioAddress),
    .ioWriteData(ioWriteData), .ioReadData(ioReadData), .ioReady(ioReady),
    .txByte(txByte), .txStart(txStart), .txBusy(txBusy)
  );

  gpioBank i_gpioBank (
    .Clk(Clk), .reset(reset), .ioAddrStrobe(ioAddrStrobe),
    .ioReadStrobe(ioReadStrobe), .ioWriteStrobe(ioWriteStrobe),
    .ioAddress(ioAddress), .ioWriteData(ioWriteData), .ioReadData(ioReadData),
    .ioReady(ioReady), .dipSw(dipSw), .led(led)
  );

  uartTransmitter i_uartTransmitter (
    .Clk(Clk), .reset(reset), .txStart(txStart), .txByte(txByte),
    .uartTx(uartTx), .txBusy(txBusy)
  );

endmodule

//--- design/mcsSysPkg.sv
package mcsSysPkg;

  // ------------------------------------------------
  // vector types
  // ------------------------------------------------
  typedef logic [7:0]  byteT;     // one uart data byte
  typedef logic [31:0] busAddrT;  // io bus address, host byte zero-extended
  typedef logic [31:0] busDataT;  // io bus data word
  typedef logic [3:0]  ledT;      // led / dip switch field

  // ------------------------------------------------
  // command engine states
  // ------------------------------------------------
  typedef enum logic [2:0] {
    idle,       // waiting for a command byte
    getAddr,    // waiting for the address byte
    getData,    // waiting for the write data byte
    busWrite,   // write strobe cycle
    busRead,    // read strobe cycle
    waitReady,  // holding for ioReady
    sendReply   // reply byte queued for the transmitter
  } cmdStateT;

endpackage

//--- design/mcsSys_defs.svh
`ifndef MCSSYS_DEFS_SVH
`define MCSSYS_DEFS_SVH

// ------------------------------------------------
// uart timing
// ------------------------------------------------
// clocks per uart bit, small for simulation, must stay >= 4
`define CLKS_PER_BIT 16

// ------------------------------------------------
// host command codes
// ------------------------------------------------
`define CMD_WRITE 8'h57
`define CMD_READ  8'h52

// ------------------------------------------------
// io bus register map
// ------------------------------------------------
`define ADDR_GPO 32'h0000_0000
`define ADDR_GPI 32'h0000_0001

`endif

//--- design/uartReceiver.sv
`timescale 1ns/10ps
`include "mcsSys_defs.svh"

module uartReceiver (
  input  logic            Clk,     // system clock
  input  logic            reset,   // sync, high
  input  logic            uartRx,  // serial in, idle high
  output mcsSysPkg::byteT rxByte,  // received byte
  output logic            rxValid  // one-cycle strobe at stop bit middle
);

  localparam int cntW = $clog2(`CLKS_PER_BIT);
  localparam logic [cntW-1:0] bitLast  = cntW'(`CLKS_PER_BIT - 1);
  localparam logic [cntW-1:0] halfLast = cntW'(`CLKS_PER_BIT / 2 - 1);

  logic            rxMeta;    // first sync stage
  logic            rxSync;    // second sync stage
  logic            rxActive;  // frame in progress
  logic [3:0]      bitCnt;    // 0 start, 1..8 data, 9 stop
  logic [cntW-1:0] phaseCnt;  // countdown to next mid-bit
  mcsSysPkg::byteT shiftReg;  // data arrives lsb first

  assign rxByte = shiftReg;

  // ------------------------------------------------
  // input synchronizer
  // ------------------------------------------------
  always_ff @(posedge Clk) begin
    if (reset) begin
      rxMeta <= 1'b1;  // line idles high
      rxSync <= 1'b1;
    end else begin
      rxMeta <= uartRx;
      rxSync <= rxMeta;
    end
  end

  // ------------------------------------------------
  // frame sampling
  // ------------------------------------------------
  always_ff @(posedge Clk) begin
    if (reset) begin
      rxActive <= 1'b0;
      bitCnt   <= 4'd0;
      phaseCnt <= '0;
      rxValid  <= 1'b0;
    end else begin
      rxValid <= 1'b0;  // pulse by default off
      if (!rxActive) begin
        if (!rxSync) begin  // falling edge seen
          rxActive <= 1'b1;
          bitCnt   <= 4'd0;
          phaseCnt <= halfLast;  // half a bit to start middle
        end
      end else if (phaseCnt != '0) begin
        phaseCnt <= phaseCnt - 1'b1;
      end else begin
        phaseCnt <= bitLast;
        bitCnt   <= bitCnt + 4'd1;
        if (bitCnt == 4'd0) begin
          if (rxSync) rxActive <= 1'b0;  // start bit glitch dropped
        end else if (bitCnt == 4'd9) begin
          rxActive <= 1'b0;     // frame done either way
          rxValid  <= rxSync;   // framing error when stop bit is low
        end
      end
    end
  end

  // payload shift
  always_ff @(posedge Clk) begin
    if (rxActive && phaseCnt == '0 && bitCnt >= 4'd1 && bitCnt <= 4'd8) begin
      shiftReg <= {rxSync, shiftReg[7:1]};  // lsb arrives first
    end
  end

endmodule

//--- design/uartTransmitter.sv
`timescale 1ns/10ps
`include "mcsSys_defs.svh"

module uartTransmitter (
  input  logic            Clk,      // system clock
  input  logic            reset,    // sync, high
  input  logic            txStart,  // one-cycle load strobe
  input  mcsSysPkg::byteT txByte,   // byte to send
  output logic            uartTx,   // serial out, idle high
  output logic            txBusy    // high for the whole frame
);

  localparam int cntW = $clog2(`CLKS_PER_BIT);
  localparam logic [cntW-1:0] bitLast = cntW'(`CLKS_PER_BIT - 1);

  logic [9:0]      frame;     // stop, data, start; bit 0 on the line
  logic [3:0]      bitCnt;    // bit currently on the line
  logic [cntW-1:0] phaseCnt;  // clocks left in this bit

  assign uartTx = frame[0];  // all ones when idle

  // ------------------------------------------------
  // frame shifter
  // ------------------------------------------------
  always_ff @(posedge Clk) begin
    if (reset) begin
      frame    <= '1;
      bitCnt   <= 4'd0;
      phaseCnt <= '0;
      txBusy   <= 1'b0;
    end else if (!txBusy) begin
      if (txStart) begin
        frame    <= {1'b1, txByte, 1'b0};  // start bit goes out next cycle
        bitCnt   <= 4'd0;
        phaseCnt <= bitLast;
        txBusy   <= 1'b1;
      end
    end else if (phaseCnt != '0) begin
      phaseCnt <= phaseCnt - 1'b1;
    end else if (bitCnt == 4'd9) begin
      txBusy <= 1'b0;  // end of stop bit
    end else begin
      frame    <= {1'b1, frame[9:1]};  // refill with idle level
      bitCnt   <= bitCnt + 4'd1;
      phaseCnt <= bitLast;
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the mcsSys testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module mcsSysTb -o mcsSysSim

# the simulator exits non-zero on a failed check, so the output decides
simOut=$(./obj_dir/mcsSysSim 2>&1) || true
echo "$simOut"

if echo "$simOut" | grep -q "^Result: PASSED$"; then
  exit 0
else
  exit 1
fi

//--- src.f
+incdir+design
design/mcsSysPkg.sv
design/uartReceiver.sv
design/uartTransmitter.sv
design/hostCommandEngine.sv
design/gpioBank.sv
design/mcsSys.sv
verification/mcsSysTb.sv

//--- verification/mcsSysTb.sv
`timescale 1ns/10ps
`include "mcsSys_defs.svh"

module mcsSysTb;

  localparam int bitClks    = `CLKS_PER_BIT;
  localparam int replyLimit = 30 * `CLKS_PER_BIT;  // cycles to wait for a reply start bit
  localparam int ledLimit   = 4 * `CLKS_PER_BIT;
  localparam mcsSysPkg::byteT gpoAddr = 8'(`ADDR_GPO);
  localparam mcsSysPkg::byteT gpiAddr = 8'(`ADDR_GPI);

  logic            Clk;
  logic            reset;
  logic            uartRx;
  logic            uartTx;
  mcsSysPkg::ledT  dipSw;
  mcsSysPkg::ledT  led;
  mcsSysPkg::byteT gpoModel;       // expected output register
  int unsigned     rngState = 7;   // lcg state

  mcsSys i_mcsSys (
    .Clk(Clk), .reset(reset), .uartRx(uartRx), .uartTx(uartTx), .led(led), .dipSw(dipSw)
  );

  always #10 Clk = ~Clk;  // 20 ns period

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  function automatic mcsSysPkg::byteT nextRandom();
    rngState = rngState * 32'd1103515245 + 32'd12345;
    return rngState[23:16];  // upper bits spread better
  endfunction

  task automatic stopRun();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped after a failed check");
  endtask

  task automatic checkValue(input string sigName, input logic [31:0] expVal,
                            input logic [31:0] actVal);
    assert (actVal === expVal) else begin
      $display("CHECK FAILED at %0t: %s expected 0x%0h, actual 0x%0h",
               $time, sigName, expVal, actVal);
      stopRun();
    end
  endtask

  task automatic reportTimeout(input string what);
    $display("TIMEOUT at %0t: %s", $time, what);
    stopRun();
  endtask

  // host side 8N1 serializer sending lsb first
  task automatic sendByte(input mcsSysPkg::byteT data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(negedge Clk);
      uartRx = frame[i];
      repeat (bitClks - 1) @(negedge Clk);  // hold for one bit time
    end
  endtask

  // decodes one frame from uartTx at mid-bit
  task automatic receiveByte(output mcsSysPkg::byteT data);
    int waitCnt;
    waitCnt = 0;
    while (uartTx !== 1'b0) begin
      if (waitCnt >= replyLimit) begin
        reportTimeout("no reply start bit appeared on uartTx");
      end else begin
        @(negedge Clk);
        waitCnt++;
      end
    end
    repeat (bitClks / 2) @(negedge Clk);  // to middle of start bit
    checkValue("uartTx start bit", 0, uartTx);
    for (int i = 0; i < 8; i++) begin
      repeat (bitClks) @(negedge Clk);
      data[i] = uartTx;
    end
    repeat (bitClks) @(negedge Clk);
    checkValue("uartTx stop bit", 1, uartTx);
  endtask

  // line must stay idle with no reply frame
  task automatic expectSilence(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge Clk);
      checkValue("uartTx idle", 1, uartTx);
    end
  endtask

  task automatic waitLed(input mcsSysPkg::ledT expVal);
    int waitCnt;
    waitCnt = 0;
    while (led !== expVal && waitCnt < ledLimit) begin
      @(negedge Clk);
      waitCnt++;
    end
    checkValue("led", expVal, led);  // still wrong after the limit
  endtask

  task automatic writeReg(input mcsSysPkg::byteT addr, input mcsSysPkg::byteT data);
    sendByte(`CMD_WRITE);
    sendByte(addr);
    sendByte(data);
    if (addr == gpoAddr) gpoModel = data;  // only address 0 is writable
    waitLed(gpoModel[3:0]);
  endtask

  task automatic readReg(input mcsSysPkg::byteT addr, output mcsSysPkg::byteT data);
    sendByte(`CMD_READ);
    fork  // reply can start before the stop bit ends
      sendByte(addr);
      receiveByte(data);
    join
  endtask

  // register map as seen from the host
  function automatic mcsSysPkg::byteT expectedRead(input mcsSysPkg::byteT addr);
    if (addr == gpoAddr) return gpoModel;
    if (addr == gpiAddr) return {4'h0, dipSw};
    return 8'h00;
  endfunction

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  initial begin
    mcsSysPkg::byteT rdData;
    mcsSysPkg::byteT tmp;
    Clk      = 1'b0;
    reset    = 1'b1;
    uartRx   = 1'b1;  // line idle
    dipSw    = 4'h0;
    gpoModel = 8'h00;
    repeat (2) @(negedge Clk);
    reset = 1'b0;

    checkValue("led after reset", 0, led);
    expectSilence(20 * bitClks);

    for (int k = 0; k < 6; k++) begin  // random writes to address 0
      writeReg(gpoAddr, nextRandom());
      readReg(gpoAddr, rdData);
      checkValue("read data addr 0", expectedRead(gpoAddr), rdData);
    end

    for (int k = 0; k < 4; k++) begin  // switch readback
      tmp = nextRandom();
      @(negedge Clk);
      dipSw = tmp[3:0];
      readReg(gpiAddr, rdData);
      checkValue("read data addr 1", expectedRead(gpiAddr), rdData);
    end

    tmp = nextRandom();
    if (tmp < 8'd2) tmp = tmp + 8'd2;  // keep it unmapped
    readReg(tmp, rdData);
    checkValue("read data unmapped", expectedRead(tmp), rdData);
    writeReg(tmp, ~gpoModel);  // would flip every bit if it landed
    readReg(gpoAddr, rdData);
    checkValue("read data addr 0 after unmapped write", gpoModel, rdData);
    checkValue("led after unmapped write", gpoModel[3:0], led);

    sendByte(8'h3C);  // not a command code
    expectSilence(15 * bitClks);
    tmp = nextRandom();
    writeReg(gpoAddr, {tmp[7:4], ~gpoModel[3:0]});  // led must visibly change

    // --------------------------------------------------
    // back to back write then two reads
    // --------------------------------------------------
    tmp = nextRandom();
    @(negedge Clk);
    dipSw = tmp[7:4];
    writeReg(gpoAddr, nextRandom());
    readReg(gpoAddr, rdData);
    checkValue("back to back read addr 0", expectedRead(gpoAddr), rdData);
    readReg(gpiAddr, rdData);
    checkValue("back to back read addr 1", expectedRead(gpiAddr), rdData);

    $display("Result: PASSED");
    $finish;
  end

endmodule
